// ==== include/aes_defs.svh ====
`ifndef AES_DEFS_SVH
`define AES_DEFS_SVH

// AES-256 round count
`define AES_ROUNDS 14

// Key length in 32-bit words
`define AES_NK 8

// Flag register layout, bits 2 to 4 reserved
`define FLAG_ENABLE 0
`define FLAG_START 1
`define CTRL_FLAGS 5

`endif

// ==== src/aes_pkg.sv ====
`include "aes_defs.svh"

package aes_pkg;

    // One state byte
    typedef logic [7:0] aes_byte_t;

    // Column of the state or one key word
    typedef logic [31:0] aes_word_t;

    // Byte 0 sits in the top bits, as in FIPS-197
    typedef logic [127:0] aes_block_t;

    typedef logic [255:0] aes_key_t;

    typedef logic [3:0] round_t;

    typedef logic [`CTRL_FLAGS-1:0] ctrl_flags_t;

    // Round sequencer states
    typedef enum logic [1:0]
    {
        IDLE,
        ROUND,
        FINISH
    } core_state_t;

endpackage

// ==== src/aes_sbox.sv ====
`timescale 1ns/100ps

module aes_sbox
(
    input  aes_pkg::aes_byte_t in,
    output aes_pkg::aes_byte_t out
);

    // Forward S-box, entry 0 in the top byte
    localparam logic [2047:0] SBOX =
    {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    // Entry n starts at bit 8*(255-n), which is the inverted index times 8
    assign out = SBOX[{~in, 3'b000} +: 8];

endmodule

// ==== src/aes_ctrl_regs.sv ====
`timescale 1ns/100ps
`include "aes_defs.svh"

module aes_ctrl_regs
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wr,
    input  logic [1:0]          addr,
    input  logic [15:0]         pos,
    input  logic                flag_val,
    input  aes_pkg::aes_block_t data,
    input  logic                busy,
    output logic                start,
    output aes_pkg::aes_block_t plaintext,
    output aes_pkg::aes_key_t   key
);

    aes_pkg::ctrl_flags_t flags_q;
    aes_pkg::aes_block_t  key_hi_q;
    aes_pkg::aes_block_t  key_lo_q;
    logic                 flag_wr;

    // Positions past the flag register are dropped
    assign flag_wr = wr && (addr == 2'd0) && (pos < 16'(`CTRL_FLAGS));

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            flags_q <= '0;
        end
        else
        begin
            // Start flag clears itself the next cycle
            flags_q[`FLAG_START] <= 1'b0;
            if (flag_wr)
            begin
                flags_q[pos[2:0]] <= flag_val;
            end
        end
    end

    // Single gate for new jobs
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            start <= 1'b0;
        end
        else
        begin
            start <= flags_q[`FLAG_START] && flags_q[`FLAG_ENABLE] && !busy;
        end
    end

    // Data registers hold until rewritten
    always_ff @(posedge clk)
    begin
        if (wr)
        begin
            case (addr)
                2'd1: plaintext <= data;
                2'd2: key_hi_q <= data;
                2'd3: key_lo_q <= data;
                default: ;
            endcase
        end
    end

    assign key = {key_hi_q, key_lo_q};

endmodule

// ==== src/aes_key_schedule.sv ====
`timescale 1ns/100ps
`include "aes_defs.svh"

module aes_key_schedule
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                key_load,
    input  logic                key_step,
    input  aes_pkg::aes_key_t   key,
    output aes_pkg::aes_block_t round_key
);

    aes_pkg::aes_word_t win [`AES_NK];
    aes_pkg::aes_word_t new_w [4];
    aes_pkg::aes_byte_t sub_b [4];
    aes_pkg::aes_word_t sub_w;
    aes_pkg::aes_word_t tmp;
    aes_pkg::aes_byte_t rcon;
    logic               show_lo;
    logic               odd_group;

    // SubWord on the newest word of the window
    for (genvar i = 0; i < 4; i++)
    begin : g_sub
        aes_sbox sbox_inst
        (
            .in  (win[`AES_NK-1][8*i +: 8]),
            .out (sub_b[i])
        );
    end

    always_comb
    begin
        sub_w = {sub_b[3], sub_b[2], sub_b[1], sub_b[0]};
        // RotWord commutes with SubWord, so rotate after the lookup
        if (!odd_group)
            tmp = {sub_w[23:0], sub_w[31:24]} ^ {rcon, 24'h000000};
        else
            tmp = sub_w;
        new_w[0] = win[0] ^ tmp;
        new_w[1] = win[1] ^ new_w[0];
        new_w[2] = win[2] ^ new_w[1];
        new_w[3] = win[3] ^ new_w[2];
    end

    // Window slides by four words per new group
    always_ff @(posedge clk)
    begin
        if (key_load)
        begin
            for (int i = 0; i < `AES_NK; i++)
                win[i] <= key[255-32*i -: 32];
        end
        else if (key_step && show_lo)
        begin
            for (int i = 0; i < 4; i++)
            begin
                win[i]     <= win[i+4];
                win[i + 4] <= new_w[i];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            show_lo   <= 1'b0;
            odd_group <= 1'b0;
            rcon      <= 8'h01;
        end
        else if (key_load)
        begin
            // A step with the load skips round key 0, already applied by the core
            show_lo   <= key_step;
            odd_group <= 1'b0;
            rcon      <= 8'h01;
        end
        else if (key_step)
        begin
            if (!show_lo)
                show_lo <= 1'b1;
            else
            begin
                odd_group <= !odd_group;
                if (!odd_group)
                    rcon <= {rcon[6:0], 1'b0} ^ (rcon[7] ? 8'h1b : 8'h00);
            end
        end
    end

    assign round_key = show_lo ? {win[4], win[5], win[6], win[7]}
                               : {win[0], win[1], win[2], win[3]};

endmodule

// ==== src/aes_round.sv ====
`timescale 1ns/100ps

module aes_round
(
    input  aes_pkg::aes_block_t state,
    input  aes_pkg::aes_block_t round_key,
    input  logic                final_round,
    output aes_pkg::aes_block_t next_state
);

    aes_pkg::aes_byte_t  sb [16];
    aes_pkg::aes_byte_t  sr [16];
    aes_pkg::aes_byte_t  mc [16];
    aes_pkg::aes_block_t mixed;

    // Multiply by x in GF(2^8)
    function automatic aes_pkg::aes_byte_t xtime(input aes_pkg::aes_byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // SubBytes
    for (genvar i = 0; i < 16; i++)
    begin : g_sub
        aes_sbox sbox_inst
        (
            .in  (state[127-8*i -: 8]),
            .out (sb[i])
        );
    end

    // ShiftRows, row r rotates left by r columns
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
                sr[4*c + r] = sb[4*((c + r) % 4) + r];
        end
    end

    // MixColumns
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            mc[4*c]     = xtime(sr[4*c]) ^ xtime(sr[4*c+1]) ^ sr[4*c+1]
                        ^ sr[4*c+2] ^ sr[4*c+3];
            mc[4*c + 1] = sr[4*c] ^ xtime(sr[4*c+1]) ^ xtime(sr[4*c+2])
                        ^ sr[4*c+2] ^ sr[4*c+3];
            mc[4*c + 2] = sr[4*c] ^ sr[4*c+1] ^ xtime(sr[4*c+2])
                        ^ xtime(sr[4*c+3]) ^ sr[4*c+3];
            mc[4*c + 3] = xtime(sr[4*c]) ^ sr[4*c] ^ sr[4*c+1]
                        ^ sr[4*c+2] ^ xtime(sr[4*c+3]);
        end
    end

    // Last round has no MixColumns
    always_comb
    begin
        for (int i = 0; i < 16; i++)
            mixed[127-8*i -: 8] = final_round ? sr[i] : mc[i];
    end

    // AddRoundKey
    assign next_state = mixed ^ round_key;

endmodule

// ==== src/aes_core.sv ====
`timescale 1ns/100ps
`include "aes_defs.svh"

module aes_core
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  aes_pkg::aes_block_t plaintext,
    input  aes_pkg::aes_key_t   key,
    output logic                busy,
    output logic                key_load,
    output logic                key_step,
    output aes_pkg::aes_block_t result,
    output logic                finish
);

    aes_pkg::core_state_t state_q;
    aes_pkg::round_t      rnd_q;
    aes_pkg::aes_block_t  data_q;
    aes_pkg::aes_block_t  round_out;
    aes_pkg::aes_block_t  round_key;
    logic                 final_round;

    assign final_round = (rnd_q == aes_pkg::round_t'(`AES_ROUNDS));

    assign key_load = (state_q == aes_pkg::IDLE) && start;
    // No new key is needed after the last round
    assign key_step = key_load || ((state_q == aes_pkg::ROUND) && !final_round);

    assign busy   = start || (state_q != aes_pkg::IDLE);
    assign finish = (state_q == aes_pkg::FINISH);
    assign result = data_q;

    aes_key_schedule key_schedule_inst
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .key_load  (key_load),
        .key_step  (key_step),
        .key       (key),
        .round_key (round_key)
    );

    aes_round round_inst
    (
        .state       (data_q),
        .round_key   (round_key),
        .final_round (final_round),
        .next_state  (round_out)
    );

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state_q <= aes_pkg::IDLE;
            rnd_q   <= '0;
        end
        else
        begin
            case (state_q)
                aes_pkg::IDLE:
                begin
                    if (start)
                    begin
                        state_q <= aes_pkg::ROUND;
                        rnd_q   <= 4'd1;
                    end
                end
                aes_pkg::ROUND:
                begin
                    if (final_round)
                        state_q <= aes_pkg::FINISH;
                    else
                        rnd_q <= rnd_q + 4'd1;
                end
                default:
                begin
                    state_q <= aes_pkg::IDLE;
                end
            endcase
        end
    end

    // Whitening with round key 0 straight from the key input
    always_ff @(posedge clk)
    begin
        if (key_load)
            data_q <= plaintext ^ key[255:128];
        else if (state_q == aes_pkg::ROUND)
            data_q <= round_out;
    end

endmodule

// ==== src/aes_out_reg.sv ====
`timescale 1ns/100ps

module aes_out_reg
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                finish,
    input  aes_pkg::aes_block_t result,
    output aes_pkg::aes_block_t enc_data,
    output logic                done
);

    // Ciphertext and done change on the same edge
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            enc_data <= '0;
            done     <= 1'b0;
        end
        else
        begin
            done <= finish;
            if (finish)
            begin
                enc_data <= result;
            end
        end
    end

endmodule

// ==== src/aes256_enc.sv ====
`timescale 1ns/100ps

module aes256_enc
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wr,
    input  logic [1:0]          addr,
    input  logic [15:0]         pos,
    input  logic                flag_val,
    input  aes_pkg::aes_block_t data,
    output aes_pkg::aes_block_t enc_data,
    output logic                done,
    output logic                busy
);

    logic                start;
    logic                finish;
    aes_pkg::aes_block_t plaintext;
    aes_pkg::aes_key_t   key;
    aes_pkg::aes_block_t result;

    // Host register port
    aes_ctrl_regs ctrl_regs_inst
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr        (wr),
        .addr      (addr),
        .pos       (pos),
        .flag_val  (flag_val),
        .data      (data),
        .busy      (busy),
        .start     (start),
        .plaintext (plaintext),
        .key       (key)
    );

    // Round per cycle datapath, key strobes stay internal
    aes_core core_inst
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .plaintext (plaintext),
        .key       (key),
        .busy      (busy),
        .key_load  (),
        .key_step  (),
        .result    (result),
        .finish    (finish)
    );

    aes_out_reg out_reg_inst
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .finish   (finish),
        .result   (result),
        .enc_data (enc_data),
        .done     (done)
    );

endmodule

// ==== bench/tb_aes256_enc.sv ====
`timescale 1ns/100ps
`include "aes_defs.svh"

module tb_aes256_enc;

    // Known-answer vectors from FIPS-197 C.3 and SP 800-38A F.1.5
    localparam aes_pkg::aes_key_t FIPS_KEY =
        256'h000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f;
    localparam aes_pkg::aes_block_t FIPS_PT = 128'h00112233445566778899aabbccddeeff;
    localparam aes_pkg::aes_block_t FIPS_CT = 128'h8ea2b7ca516745bfeafc49904b496089;
    localparam aes_pkg::aes_key_t SP_KEY =
        256'h603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4;
    localparam aes_pkg::aes_block_t SP_PT1 = 128'h6bc1bee22e409f96e93d7e117393172a;
    localparam aes_pkg::aes_block_t SP_CT1 = 128'hf3eed1bdb5d2a03c064b5a7e3db181f8;
    localparam aes_pkg::aes_block_t SP_PT2 = 128'hae2d8a571e03ac9c9eb76fac45af8e51;
    localparam aes_pkg::aes_block_t SP_CT2 = 128'h591ccb10d410ed26dc5ba74a31362870;
    localparam aes_pkg::aes_block_t SP_PT3 = 128'h30c81c46a35ce411e5fbc1191a0a52ef;
    localparam aes_pkg::aes_block_t SP_CT3 = 128'hb6ed21b99ca6f4f9f153e7b1beafed1d;

    logic                clk;
    logic                rst_n;
    logic                wr;
    logic [1:0]          addr;
    logic [15:0]         pos;
    logic                flag_val;
    aes_pkg::aes_block_t data;
    aes_pkg::aes_block_t enc_data;
    logic                done;
    logic                busy;
    integer              seed = 32'hef91;

    aes256_enc aes256_enc_inst
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr       (wr),
        .addr     (addr),
        .pos      (pos),
        .flag_val (flag_val),
        .data     (data),
        .enc_data (enc_data),
        .done     (done),
        .busy     (busy)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_on_failure();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_block(input string name, input aes_pkg::aes_block_t expected,
                               input aes_pkg::aes_block_t actual);
        if (actual !== expected)
        begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("ERROR %s: expected %b, actual %b", name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic write_reg(input logic [1:0] a, input aes_pkg::aes_block_t d);
        @(posedge clk);
        wr   <= 1'b1;
        addr <= a;
        data <= d;
        @(posedge clk);
        wr <= 1'b0;
    endtask

    task automatic set_flag(input logic [15:0] p, input logic v);
        @(posedge clk);
        wr       <= 1'b1;
        addr     <= 2'd0;
        pos      <= p;
        flag_val <= v;
        @(posedge clk);
        wr <= 1'b0;
    endtask

    task automatic load_key(input aes_pkg::aes_key_t k);
        write_reg(2'd2, k[255:128]);
        write_reg(2'd3, k[127:0]);
    endtask

    task automatic idle_gap();
        int gap;
        gap = ($random(seed) & 7) + 1;
        repeat (gap) @(posedge clk);
    endtask

    // Values seen here are the ones held during the cycle that just ended
    task automatic wait_done(input string name, input int limit);
        int n;
        n = 0;
        while (done !== 1'b1)
        begin
            if (n >= limit)
            begin
                $display("%s: no done pulse within %0d cycles", name, limit);
                stop_on_failure();
            end
            @(posedge clk);
            n++;
        end
    endtask

    task automatic wait_busy(input string name, input int limit);
        int n;
        n = 0;
        while (busy !== 1'b1)
        begin
            if (n >= limit)
            begin
                $display("%s: busy never went high within %0d cycles", name, limit);
                stop_on_failure();
            end
            @(posedge clk);
            n++;
        end
    endtask

    task automatic encrypt_and_check(input string name, input aes_pkg::aes_block_t expected);
        set_flag(16'(`FLAG_START), 1'b1);
        wait_done(name, 40);
        check_block(name, expected, enc_data);
        check_bit({name, " busy at done"}, 1'b0, busy);
        idle_gap();
    endtask

    task automatic test_fips_vector();
        load_key(FIPS_KEY);
        idle_gap();
        write_reg(2'd1, FIPS_PT);
        encrypt_and_check("fips197", FIPS_CT);
    endtask

    // Rewriting both key halves replaces the FIPS key
    task automatic test_sp_vector();
        load_key(SP_KEY);
        idle_gap();
        write_reg(2'd1, SP_PT1);
        encrypt_and_check("sp800_38a", SP_CT1);
    endtask

    // Only the plaintext changes and the key registers keep the SP key
    task automatic test_key_reuse();
        write_reg(2'd1, SP_PT2);
        encrypt_and_check("key_reuse", SP_CT2);
    endtask

    task automatic test_enable_clear();
        aes_pkg::aes_block_t held;
        held = enc_data;
        set_flag(16'(`FLAG_ENABLE), 1'b0);
        set_flag(16'(`FLAG_START), 1'b1);
        repeat (40)
        begin
            @(posedge clk);
            check_bit("enable_clear done", 1'b0, done);
            check_bit("enable_clear busy", 1'b0, busy);
        end
        check_block("enable_clear hold", held, enc_data);
        set_flag(16'(`FLAG_ENABLE), 1'b1);
        // Position 9 aliases the start bit in its low bits
        set_flag(16'd9, 1'b1);
        repeat (20)
        begin
            @(posedge clk);
            check_bit("out_of_range pos done", 1'b0, done);
            check_bit("out_of_range pos busy", 1'b0, busy);
        end
        idle_gap();
    endtask

    task automatic test_busy_hold();
        aes_pkg::aes_block_t held;
        write_reg(2'd1, SP_PT3);
        set_flag(16'(`FLAG_START), 1'b1);
        wait_busy("busy_hold", 10);
        // Second start lands while the core is running
        set_flag(16'(`FLAG_START), 1'b1);
        check_bit("busy_hold busy", 1'b1, busy);
        wait_done("busy_hold", 40);
        check_block("busy_hold", SP_CT3, enc_data);
        check_bit("busy_hold busy at done", 1'b0, busy);
        held = enc_data;
        repeat (30)
        begin
            @(posedge clk);
            check_bit("busy_hold extra done", 1'b0, done);
            check_block("busy_hold result", held, enc_data);
        end
        idle_gap();
        check_block("busy_hold after gap", held, enc_data);
    endtask

    initial
    begin
        rst_n    = 1'b0;
        wr       = 1'b0;
        addr     = 2'd0;
        pos      = 16'd0;
        flag_val = 1'b0;
        data     = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        @(posedge clk);
        check_bit("reset done", 1'b0, done);
        check_bit("reset busy", 1'b0, busy);
        check_block("reset enc_data", '0, enc_data);

        set_flag(16'(`FLAG_ENABLE), 1'b1);
        test_fips_vector();
        test_sp_vector();
        test_key_reuse();
        test_enable_clear();
        test_busy_hold();

        $display("TEST OK");
        $finish;
    end

endmodule

// ==== aes256_enc.f ====
+incdir+include
src/aes_pkg.sv
src/aes_sbox.sv
src/aes_ctrl_regs.sv
src/aes_key_schedule.sv
src/aes_round.sv
src/aes_core.sv
src/aes_out_reg.sv
src/aes256_enc.sv
bench/tb_aes256_enc.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_aes256_enc
FILELIST  = aes256_enc.f
SIM       = obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf obj_dir
